// File: hw/opPkg.sv
// Opcode, timing state and ALU operation encodings
// Command word driven by dispatch into the data side
`default_nettype none

package opPkg;

	// Supported subset, real 6502 encodings
	typedef enum logic [7:0] {
		opLdaImm = 8'hA9,	// A <= #imm
		opLdxImm = 8'hA2,	// X <= #imm
		opAdcImm = 8'h69,	// A <= A + #imm + C
		opAndImm = 8'h29,	// A <= A & #imm
		opOraImm = 8'h09,	// A <= A | #imm
		opEorImm = 8'h49,	// A <= A ^ #imm
		opStaAbs = 8'h8D,	// mem[abs] <= A
		opTax    = 8'hAA,	// X <= A
		opInx    = 8'hE8,	// X <= X + 1
		opJmpAbs = 8'h4C,	// PC <= abs
		opClc    = 8'h18,	// C <= 0
		opSec    = 8'h38	// C <= 1
	} opcodeT;

	typedef enum logic [1:0] {
		tFetch   = 2'd0,	// Opcode fetch, sync high
		tOperand = 2'd1,	// Immediate operand, low address byte or dummy read
		tAddrHi  = 2'd2,	// High address byte
		tWrite   = 2'd3		// Store of A
	} stateT;

	typedef enum logic [2:0] {
		aluPass = 3'd0,		// Operand B through
		aluAdc  = 3'd1,		// A + B + C
		aluAnd  = 3'd2,
		aluOra  = 3'd3,
		aluEor  = 3'd4,
		aluInc  = 3'd5,		// Operand A + 1
		aluTfr  = 3'd6		// Operand A through, for TAX
	} aluOpT;

	// Command word for one cycle of the data side
	typedef struct packed {
		aluOpT aluOp;
		logic  srcX;		// ALU operand A from X
		logic  loadA;
		logic  loadX;
		logic  setFlagsNZ;
		logic  setCarry;
		logic  clrCarry;
		logic  pcInc;
		logic  pcLoad;
	} coreCmdT;

	localparam coreCmdT cmdIdle = '{aluOp: aluPass, default: '0};	// Nothing happens

endpackage

`default_nettype wire

// File: hw/busPkg.sv
// External bus request word and data width
`default_nettype none

package busPkg;

	localparam int dataWidth = 8;	// Byte-wide data bus

	// Request presented after each rising edge of phi0
	typedef struct packed {
		logic [15:0]          addr;		// Address bus
		logic [dataWidth-1:0] dataOut;	// Write data, valid when rnw low
		logic                 rnw;		// 1 read, 0 write
		logic                 sync;		// Opcode fetch cycle
	} busReqT;

endpackage

`default_nettype wire

// File: hw/dispatch.sv
// Timing state machine and opcode decode
// Holds the opcode and absolute address bytes, drives cmd and bus control
`timescale 1ns/100ps
`default_nettype none

module dispatch (
	input  logic           phi0,		// Core clock
	input  logic           rstN,
	input  logic           rdy,			// Low stalls the core
	input  logic [7:0]     dataIn,		// Read data from memory
	input  logic [15:0]    pc,
	output opPkg::coreCmdT cmd,
	output logic [7:0]     operandLo,	// Low address byte, to jump path
	output logic [15:0]    addr,
	output logic           rnw,
	output logic           sync
);
	import opPkg::*;

	stateT      state;
	stateT      stateNext;
	opcodeT     opcode;			// Held from tFetch
	logic [7:0] operandHi;		// High address byte for STA
	logic       runEn;			// Low for the first cycle after reset
	logic       latchLo;
	logic       latchHi;

	// ALU operation of the accumulator immediate group
	function automatic aluOpT accOp(input opcodeT op);
		case (op)
			opAdcImm: return aluAdc;
			opAndImm: return aluAnd;
			opOraImm: return aluOra;
			opEorImm: return aluEor;
			default:  return aluPass;	// LDA
		endcase
	endfunction

	always_ff @(posedge phi0 or negedge rstN) begin
		if (!rstN) begin
			state <= tFetch;
			runEn <= 1'b0;
		end else if (rdy) begin
			state <= stateNext;
			runEn <= 1'b1;
		end
	end

	// Opcode and address bytes
	always_ff @(posedge phi0) begin
		if (rdy && runEn && state == tFetch) begin
			opcode <= opcodeT'(dataIn);		// Unlisted values decode as NOP
		end
		if (rdy && latchLo) begin
			operandLo <= dataIn;
		end
		if (rdy && latchHi) begin
			operandHi <= dataIn;
		end
	end

	always_comb begin
		cmd       = cmdIdle;
		stateNext = tFetch;
		latchLo   = 1'b0;
		latchHi   = 1'b0;
		case (state)
			tFetch: begin
				if (runEn) begin
					cmd.pcInc = 1'b1;		// Step past the opcode
					stateNext = tOperand;
				end
			end
			tOperand: begin
				case (opcode)
					opLdaImm, opAdcImm, opAndImm, opOraImm, opEorImm: begin
						cmd.aluOp      = accOp(opcode);
						cmd.loadA      = 1'b1;
						cmd.setFlagsNZ = 1'b1;
						cmd.pcInc      = 1'b1;	// Consume the immediate
					end
					opLdxImm: begin
						cmd.aluOp      = aluPass;
						cmd.loadX      = 1'b1;
						cmd.setFlagsNZ = 1'b1;
						cmd.pcInc      = 1'b1;
					end
					opTax: begin
						cmd.aluOp      = aluTfr;	// Dummy read, PC held
						cmd.loadX      = 1'b1;
						cmd.setFlagsNZ = 1'b1;
					end
					opInx: begin
						cmd.aluOp      = aluInc;
						cmd.srcX       = 1'b1;
						cmd.loadX      = 1'b1;
						cmd.setFlagsNZ = 1'b1;
					end
					opClc: cmd.clrCarry = 1'b1;
					opSec: cmd.setCarry = 1'b1;
					opStaAbs, opJmpAbs: begin
						latchLo   = 1'b1;	// Low byte of target
						cmd.pcInc = 1'b1;
						stateNext = tAddrHi;
					end
					default: cmd = cmdIdle;	// Two-cycle NOP
				endcase
			end
			tAddrHi: begin
				if (opcode == opJmpAbs) begin
					cmd.pcLoad = 1'b1;		// Target is {dataIn, operandLo}
				end else begin
					latchHi   = 1'b1;
					cmd.pcInc = 1'b1;
					stateNext = tWrite;
				end
			end
			default: stateNext = tFetch;	// tWrite, back to fetch
		endcase
	end

	assign addr = (state == tWrite) ? {operandHi, operandLo} : pc;
	assign rnw  = (state != tWrite);
	assign sync = runEn && (state == tFetch);

endmodule

`default_nettype wire

// File: hw/pcCounter.sv
// Program counter with reset load, increment and jump load
`timescale 1ns/100ps
`default_nettype none

module pcCounter #(
	parameter logic [15:0] resetVector = 16'h0200	// First fetch address
) (
	input  logic           phi0,
	input  logic           rstN,
	input  logic           rdy,
	input  opPkg::coreCmdT cmd,
	input  logic [15:0]    jumpAddr,	// {dataIn, low latched byte}
	output logic [15:0]    pc
);

	always_ff @(posedge phi0 or negedge rstN) begin
		if (!rstN) begin
			pc <= resetVector;				// No vector fetch
		end else if (rdy) begin
			if (cmd.pcLoad) begin
				pc <= jumpAddr;				// JMP abs
			end else if (cmd.pcInc) begin
				pc <= pc + 16'd1;			// Wraps at FFFF
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/regFile.sv
// Accumulator and index register
// A also drives the store data of STA
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input  logic           phi0,
	input  logic           rstN,
	input  logic           rdy,
	input  opPkg::coreCmdT cmd,
	input  logic [7:0]     result,	// ALU output
	output logic [7:0]     aReg,	// Accumulator, also store data
	output logic [7:0]     xReg		// Index register
);

	always_ff @(posedge phi0 or negedge rstN) begin
		if (!rstN) begin
			aReg <= 8'd0;
			xReg <= 8'd0;
		end else if (rdy) begin
			if (cmd.loadA) begin
				aReg <= result;		// LDA and logic ops
			end
			if (cmd.loadX) begin
				xReg <= result;		// LDX, TAX, INX
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/alu.sv
// ALU operations and N, Z, C flag register
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  logic           phi0,
	input  logic           rstN,
	input  logic           rdy,
	input  opPkg::coreCmdT cmd,
	input  logic [7:0]     aReg,
	input  logic [7:0]     xReg,
	input  logic [7:0]     dataIn,	// Operand B
	output logic [7:0]     result
);
	import opPkg::*;

	logic [7:0] opA;
	logic [8:0] sum;		// Bit 8 is the adder carry
	logic       flagN;
	logic       flagZ;
	logic       flagC;

	assign opA = cmd.srcX ? xReg : aReg;
	assign sum = {1'b0, opA} + {1'b0, dataIn} + {8'd0, flagC};	// Carry chains into ADC

	always_comb begin
		case (cmd.aluOp)
			aluAdc:  result = sum[7:0];
			aluAnd:  result = opA & dataIn;
			aluOra:  result = opA | dataIn;
			aluEor:  result = opA ^ dataIn;
			aluInc:  result = opA + 8'd1;	// FF wraps to 00
			aluTfr:  result = opA;
			default: result = dataIn;		// aluPass
		endcase
	end

	always_ff @(posedge phi0 or negedge rstN) begin
		if (!rstN) begin
			flagN <= 1'b0;
			flagZ <= 1'b0;
			flagC <= 1'b0;
		end else if (rdy) begin
			if (cmd.clrCarry) begin
				flagC <= 1'b0;			// CLC
			end else if (cmd.setCarry) begin
				flagC <= 1'b1;			// SEC
			end else if (cmd.aluOp == aluAdc) begin
				flagC <= sum[8];
			end
			if (cmd.setFlagsNZ) begin
				flagN <= result[7];
				flagZ <= (result == 8'd0);
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/core6502Lite.sv
// Core top, control side and data side wired together
// Bus request built from dispatch outputs and A
`timescale 1ns/100ps
`default_nettype none

module core6502Lite #(
	parameter logic [15:0] resetVector = 16'h0200	// PC after reset
) (
	input  logic           phi0,
	input  logic           rstN,
	input  logic           rdy,
	input  logic [7:0]     dataIn,	// Memory read data
	output busPkg::busReqT busReq
);
	import opPkg::*;

	coreCmdT     cmd;			// Command word for this cycle
	logic [7:0]  operandLo;
	logic [7:0]  aReg;
	logic [7:0]  xReg;
	logic [7:0]  result;
	logic [15:0] pc;
	logic [15:0] addr;
	logic        rnw;
	logic        sync;

	dispatch uDispatch (
		.phi0(phi0),
		.rstN(rstN),
		.rdy(rdy),
		.dataIn(dataIn),
		.pc(pc),
		.cmd(cmd),
		.operandLo(operandLo),
		.addr(addr),
		.rnw(rnw),
		.sync(sync)
	);

	pcCounter #(
		.resetVector(resetVector)
	) uPc (
		.phi0(phi0),
		.rstN(rstN),
		.rdy(rdy),
		.cmd(cmd),
		.jumpAddr({dataIn, operandLo}),	// High byte read in tAddrHi
		.pc(pc)
	);

	regFile uRegs (
		.phi0(phi0),
		.rstN(rstN),
		.rdy(rdy),
		.cmd(cmd),
		.result(result),
		.aReg(aReg),
		.xReg(xReg)
	);

	alu uAlu (
		.phi0(phi0),
		.rstN(rstN),
		.rdy(rdy),
		.cmd(cmd),
		.aReg(aReg),
		.xReg(xReg),
		.dataIn(dataIn),
		.result(result)
	);

	assign busReq.addr    = addr;
	assign busReq.dataOut = aReg;		// STA stores A
	assign busReq.rnw     = rnw;
	assign busReq.sync    = sync;

endmodule

`default_nettype wire

// File: tb/core6502LiteTb.sv
// Clock, memory model and program loader for the core
// Reference interpreter of the subset and the bus checker
`timescale 1ns/100ps
`default_nettype none

module core6502LiteTb;
	import opPkg::*;
	import busPkg::*;

	localparam logic [15:0] resetVec = 16'h0200;

	logic        phi0 = 1'b0;
	logic        rstN = 1'b0;
	logic        rdy = 1'b1;
	logic [7:0]  dataIn;
	busReqT      busReq;
	busReqT      cap;				// Bus word of the cycle in flight
	logic        capRdy = 1'b0;
	logic        running = 1'b0;		// Checker active
	logic        stallMode = 1'b0;
	logic [7:0]  mem [0:65535];
	logic [7:0]  refMem [0:65535];	// Reference copy of the image
	logic [15:0] loadPtr;
	logic [31:0] progSeed = 32'h1345d75c;
	logic [31:0] rdySeed = 32'h1345d75c;
	logic [15:0] expFetch [$];
	logic [7:0]  expX [$];			// X seen at each fetch
	int          expCycles [$];		// Cycles per instruction
	logic [15:0] expStoreAddr [$];
	logic [7:0]  expStoreData [$];
	int          fetchIdx = 0;
	int          storeIdx = 0;
	int          cycleCount = 0;
	int          checkErrors = 0;
	int          runErrors = 0;
	int          testCount = 0;
	int          failedTests = 0;

	core6502Lite #(
		.resetVector(resetVec)
	) core6502Lite_inst (
		.phi0(phi0),
		.rstN(rstN),
		.rdy(rdy),
		.dataIn(dataIn),
		.busReq(busReq)
	);

	always #2 phi0 = ~phi0;				// 4 ns period

	assign dataIn = mem[busReq.addr];	// Combinational read

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] randByte();
		progSeed = lcgStep(progSeed);
		return progSeed[23:16];
	endfunction

	// Interprets the image, fills fetch, cycle and store lists
	function automatic void expectStore(input int nInstr);
		logic [15:0] p;
		logic [15:0] target;
		int          total;
		logic [7:0]  a;
		logic [7:0]  x;
		logic [7:0]  op;
		logic        c;
		int          i;
		expFetch.delete();
		expX.delete();
		expCycles.delete();
		expStoreAddr.delete();
		expStoreData.delete();
		p = resetVec;
		a = 8'd0;
		x = 8'd0;
		c = 1'b0;
		for (i = 0; i < nInstr; i++) begin
			expFetch.push_back(p);
			expX.push_back(x);
			op = refMem[p];
			p = p + 16'd1;
			target = {refMem[p + 16'd1], refMem[p]};	// Absolute operand
			expCycles.push_back(2);
			case (op)
				opLdaImm: a = refMem[p];
				opLdxImm: x = refMem[p];
				opAndImm: a = a & refMem[p];
				opOraImm: a = a | refMem[p];
				opEorImm: a = a ^ refMem[p];
				opAdcImm: begin
					total = int'(a) + int'(refMem[p]) + int'(c);	// Binary add with carry in
					a = total[7:0];
					c = (total > 255);
				end
				opTax: x = a;
				opInx: x = x + 8'd1;
				opClc: c = 1'b0;
				opSec: c = 1'b1;
				opStaAbs: begin
					refMem[target] = a;
					expStoreAddr.push_back(target);
					expStoreData.push_back(a);
					expCycles[i] = 4;
				end
				opJmpAbs: expCycles[i] = 3;
				default: ;					// NOP, dummy read only
			endcase
			case (op)
				opLdaImm, opLdxImm, opAndImm, opOraImm, opEorImm, opAdcImm: p = p + 16'd1;
				opStaAbs: p = p + 16'd2;
				opJmpAbs: p = target;
				default: ;
			endcase
		end
		expFetch.push_back(p);		// Fetch that closes the last instruction
		expX.push_back(x);
	endfunction

	// Compares each completed cycle, drives rdy and keeps memory
	always @(negedge phi0) begin
		if (!running) begin
			fetchIdx = 0;
			storeIdx = 0;
			cycleCount = 0;
		end else if (!capRdy) begin
			if (busReq !== cap) begin
				$display("** Error at %0t: busReq changed during a stall", $time);
				checkErrors++;
			end
		end else begin
			if (cap.sync) begin
				if (fetchIdx >= expFetch.size()) begin
					$display("** Error at %0t: unexpected fetch at %h", $time, cap.addr);
					checkErrors++;
				end else begin
					if (cap.addr !== expFetch[fetchIdx]) begin
						$display("** Error at %0t: fetch %0d at %h, expected %h", $time,
							fetchIdx, cap.addr, expFetch[fetchIdx]);
						checkErrors++;
					end
					if (cap.rnw !== 1'b1) begin
						$display("** Error at %0t: fetch with rnw low", $time);
						checkErrors++;
					end
					if (core6502Lite_inst.xReg !== expX[fetchIdx]) begin
						$display("** Error at %0t: X is %h at fetch %0d, expected %h", $time,
							core6502Lite_inst.xReg, fetchIdx, expX[fetchIdx]);
						checkErrors++;
					end
					if (fetchIdx > 0 && cycleCount != expCycles[fetchIdx - 1]) begin
						$display("** Error at %0t: %0d cycles before fetch %0d, expected %0d",
							$time, cycleCount, fetchIdx, expCycles[fetchIdx - 1]);
						checkErrors++;
					end
				end
				fetchIdx++;
				cycleCount = 1;
			end else begin
				cycleCount++;
			end
			if (!cap.rnw) begin
				mem[cap.addr] = cap.dataOut;	// Store lands in memory
				if (storeIdx >= expStoreAddr.size()) begin
					$display("** Error at %0t: unexpected store at %h", $time, cap.addr);
					checkErrors++;
				end else if (cap.addr !== expStoreAddr[storeIdx] ||
						cap.dataOut !== expStoreData[storeIdx]) begin
					$display("** Error at %0t: store %h to %h, expected %h to %h", $time,
						cap.dataOut, cap.addr, expStoreData[storeIdx], expStoreAddr[storeIdx]);
					checkErrors++;
				end
				storeIdx++;
			end
		end
		rdySeed = lcgStep(rdySeed);
		rdy = !stallMode || (rdySeed[17:16] != 2'b00);	// Low about one cycle in four
		cap = busReq;
		capRdy = rdy;
	end

	task automatic putByte(input logic [7:0] b);
		mem[loadPtr] = b;
		loadPtr = loadPtr + 16'd1;
	endtask

	task automatic putImm(input logic [7:0] op, input logic [7:0] val);
		putByte(op);
		putByte(val);
	endtask

	task automatic putAbs(input logic [7:0] op, input logic [15:0] addr);
		putByte(op);
		putByte(addr[7:0]);
		putByte(addr[15:8]);
	endtask

	task automatic fillMemory();
		int i;
		for (i = 0; i < 65536; i++) begin
			mem[i[15:0]] = i[7:0] ^ i[15:8] ^ 8'h3C;
		end
		loadPtr = resetVec;
	endtask

	task automatic buildAccumulator(output int n);
		fillMemory();
		putImm(opLdaImm, randByte());
		putAbs(opStaAbs, 16'h3000);
		putImm(opAdcImm, randByte());
		putAbs(opStaAbs, 16'h3001);
		putImm(opAndImm, randByte());
		putAbs(opStaAbs, 16'h3002);
		putImm(opOraImm, randByte());
		putAbs(opStaAbs, 16'h3003);
		putImm(opEorImm, randByte());
		putAbs(opStaAbs, 16'h3004);
		putByte(opSec);
		putImm(opAdcImm, 8'hF0);
		putAbs(opStaAbs, 16'h3005);
		putImm(opAdcImm, 8'hFF);			// Carry chains from the last ADC
		putAbs(opStaAbs, 16'h3006);
		putByte(opClc);
		putImm(opAdcImm, randByte());
		putAbs(opStaAbs, 16'h3007);
		putAbs(opJmpAbs, loadPtr);			// Park on itself
		n = 22;
	endtask

	task automatic buildIndex(output int n);
		fillMemory();
		putImm(opLdxImm, 8'hFE);
		putByte(opInx);
		putByte(opInx);						// FF wraps to 00
		putByte(opTax);
		putImm(opLdaImm, randByte());
		putAbs(opStaAbs, 16'h3010);
		putImm(opLdxImm, randByte());
		putByte(opInx);
		putByte(8'hEA);						// Unlisted opcode
		putImm(opLdaImm, randByte());
		putByte(opTax);
		putAbs(opStaAbs, 16'h3011);
		putAbs(opJmpAbs, loadPtr);
		n = 15;
	endtask

	task automatic buildJump(output int n);
		int k;
		int i;
		fillMemory();
		k = 1 + int'(randByte() % 8'd4);	// Loop body length
		putAbs(opJmpAbs, 16'h4100);
		loadPtr = 16'h4100;
		for (i = 0; i < k; i++) begin
			putImm(opAdcImm, randByte());
			putAbs(opStaAbs, 16'h3020 + 16'(i));
		end
		putAbs(opJmpAbs, 16'h4100);
		n = 1 + 3 * (2 * k + 1);			// Three passes through the loop
	endtask

	task automatic runProgram(input string name, input int nInstr, input logic stall);
		int t;
		int errsBefore;
		errsBefore = checkErrors + runErrors;
		testCount++;
		@(negedge phi0);
		rstN = 1'b0;
		@(posedge phi0);
		refMem = mem;
		expectStore(nInstr);
		stallMode = stall;
		repeat (3) @(posedge phi0);
		@(negedge phi0);
		rstN = 1'b1;
		@(posedge phi0);
		running = 1'b1;
		for (t = 0; t < 2000 && fetchIdx < expFetch.size(); t++) begin
			@(posedge phi0);
		end
		running = 1'b0;
		if (fetchIdx < expFetch.size()) begin
			$display("Timeout in %s: only %0d of %0d fetches seen", name, fetchIdx,
				expFetch.size());
			runErrors++;
		end else if (storeIdx != expStoreAddr.size()) begin
			$display("** Error at %0t: %0d stores seen, expected %0d", $time, storeIdx,
				expStoreAddr.size());
			runErrors++;
		end
		if (checkErrors + runErrors != errsBefore) begin
			failedTests++;
		end
		$display("%s: %0d instructions, %0d stores, %0d errors", name, nInstr, storeIdx,
			checkErrors + runErrors - errsBefore);
	endtask

	initial begin
		int n;
		buildAccumulator(n);
		runProgram("accumulator", n, 1'b0);
		buildIndex(n);
		runProgram("index", n, 1'b0);
		buildJump(n);
		runProgram("jump loop", n, 1'b0);
		buildAccumulator(n);
		runProgram("accumulator with stalls", n, 1'b1);
		buildJump(n);
		runProgram("jump loop with stalls", n, 1'b1);
		$display("%0d tests, %0d failed, %0d errors", testCount, failedTests,
			checkErrors + runErrors);
		if (failedTests == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
hw/opPkg.sv
hw/busPkg.sv
hw/dispatch.sv
hw/pcCounter.sv
hw/regFile.sv
hw/alu.sv
hw/core6502Lite.sv
tb/core6502LiteTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module core6502LiteTb -o simv
	./obj_dir/simv | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
